/* list.f */
+incdir+src
src/controlPkg.sv
src/opcodeDecoder.sv
src/stateSequencer.sv
src/controlDecoder.sv
src/controlTop.sv
verification/clockGen.sv
verification/control_props.sv
verification/controlTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = controlTb
FILELIST = list.f
OBJDIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the simulator exits with a failing status on $fatal.
sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

/* verification/controlTb.sv */
`timescale 1ns/1ns
`include "control_defines.svh"

module controlTb
   import controlPkg::*;
();

   localparam int TIMEOUT_CYCLES = 400;
   localparam int RESET_CYCLES   = 3;
   localparam int DRIVE_DELAY    = 5;
   localparam int SAMPLE_DELAY   = 40; // outputs settled well before the next edge.
   localparam int RANDOM_COUNT   = 40;
   localparam int MAX_LENGTH     = 8;

   logic        CLK;
   logic        Reset;
   opcodeT      opcode;
   stateT       state;
   controlWordT control;
   int          cycles = 0;
   integer      seed;

   clockGen clockGen
   (
      .CLK (CLK)
   );

   controlTop UUT
   (
      .CLK     (CLK),
      .Reset   (Reset),
      .opcode  (opcode),
      .state   (state),
      .control (control)
   );

   always @(posedge CLK)
   begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("sim failed");
         $fatal(1, "timeout");
      end
   end

   function automatic aluOpT aluFuncModel(opcodeT op);
      case (op)
         `OP_AND: return `ALU_AND;
         `OP_OR:  return `ALU_OR;
         `OP_SUB: return `ALU_SUB;
         `OP_SLT: return `ALU_SLT;
         default: return `ALU_ADD;
      endcase
   endfunction

   function automatic stateT nextStateModel(stateT s, opcodeT op);
      case (s)
         fetch: return decode;
         decode:
         begin
            case (op)
               `OP_ADD, `OP_AND, `OP_OR, `OP_SUB, `OP_SLT: return rExecute;
               `OP_SW, `OP_LW:   return address;
               `OP_BEQ, `OP_BNE: return bExecute;
               `OP_ADDI:         return iExecute;
               `OP_J:            return jExecute;
               `OP_JR:           return jrExecute;
               `OP_LUI:          return luiExecute;
               `OP_LI:           return liExecute;
               default:          return fetch;
            endcase
         end
         address:   return (op == `OP_SW) ? swDone : lwExecute;
         lwExecute: return lwDone;
         bExecute:  return (op == `OP_BEQ) ? beqDone : bneDone;
         rExecute:  return rWrite;
         iExecute:  return iWrite;
         default:   return fetch;
      endcase
   endfunction

   // expected control word, row by row from the state table.
   function automatic controlWordT wordModel(stateT s, opcodeT op);
      controlWordT w;
      w          = '0;
      w.pcSource = `PC_SRC_IDLE;
      case (s)
         fetch:
         begin
            w.aluOutSrc = 2'd1;
            w.aluSrc1   = 2'd2;
            w.aluSrc2   = 2'd1;
            w.aluOp     = `ALU_ADD;
            w.irWrite   = 1'b1;
            w.pcWrite   = 1'b1;
            w.pcSource  = 2'd1;
         end
         decode:
         begin
            w.regWrite = 1'b1;
            w.aluSrc2  = 2'd2;
            w.aluOp    = `ALU_ADD;
         end
         rExecute:
         begin
            w.aluOutSrc = 2'd3;
            w.iorD      = 2'd1;
            w.mdrWrite  = 1'b1;
            w.aluSrc1   = 2'd3;
            w.aluOp     = aluFuncModel(op);
         end
         rWrite, iWrite:
         begin
            w.regWrite = 1'b1;
            w.regSrc   = 3'd4;
         end
         address:   w.aluOutSrc = 2'd3;
         lwExecute: w.iorD = 2'd2;
         swDone:
         begin
            w.memWrite = 1'b1;
            w.iorD     = 2'd1;
         end
         lwDone:
         begin
            w.regWrite = 1'b1;
            w.regSrc   = 3'd1;
         end
         bExecute:
         begin
            w.aluSrc1 = 2'd1;
            w.aluOp   = `ALU_SUB;
         end
         beqDone, bneDone:
         begin
            w.beq       = (s == beqDone);
            w.bne       = (s == bneDone);
            w.aluOp     = `ALU_ADD;
            w.aluSrc1   = 2'd2;
            w.aluSrc2   = 2'd3;
            w.aluOutSrc = 2'd1;
            w.pcWrite   = 1'b1;
         end
         jExecute:
         begin
            w.pcWrite  = 1'b1;
            w.pcSource = 2'd2;
         end
         jrExecute:
         begin
            w.iorD     = 2'd2;
            w.regWrite = 1'b1;
            w.pcWrite  = 1'b1;
            w.pcSource = 2'd1;
         end
         iExecute: w.aluOp = aluFuncModel(op);
         luiExecute:
         begin
            w.regWrite = 1'b1;
            w.regSrc   = 3'd2;
         end
         liExecute:
         begin
            w.regWrite  = 1'b1;
            w.aluOutSrc = 2'd2;
         end
         default: w.pcSource = `PC_SRC_IDLE;
      endcase
      return w;
   endfunction

   // instruction lengths in cycles, fetch included.
   function automatic int cycleCountModel(opcodeT op);
      case (op)
         `OP_ADD, `OP_AND, `OP_OR, `OP_SUB, `OP_SLT: return 4;
         `OP_SW, `OP_BEQ, `OP_BNE, `OP_ADDI:         return 4;
         `OP_LW:                                     return 5;
         `OP_J, `OP_JR, `OP_LUI, `OP_LI:             return 3;
         default:                                    return 2;
      endcase
   endfunction

   task automatic advanceCycle();
      @(posedge CLK);
      #DRIVE_DELAY;
   endtask

   task automatic checkState(stateT expected);
      if (state !== expected)
      begin
         $display("Error: state expected %h actual %h", expected, state);
         $display("sim failed");
         $fatal(1, "state mismatch");
      end
   endtask

   task automatic checkControl(controlWordT expected);
      if (control !== expected)
      begin
         $display("Error: control expected %h actual %h", expected, control);
         $display("sim failed");
         $fatal(1, "control word mismatch");
      end
   endtask

   task automatic checkCycles(int expected, int actual);
      if (actual != expected)
      begin
         $display("Error: cycles expected %h actual %h", expected, actual);
         $display("sim failed");
         $fatal(1, "instruction length mismatch");
      end
   endtask

   // starts in a fetch cycle and returns in the next one.
   task automatic runInstruction(opcodeT op);
      stateT s;
      int    count;
      s      = fetch;
      count  = 0;
      opcode = op;
      do
      begin
         #SAMPLE_DELAY;
         checkState(s);
         checkControl(wordModel(s, op));
         s = nextStateModel(s, op);
         count++;
         advanceCycle();
      end
      while (state != fetch && count < MAX_LENGTH); // the DUT ends the instruction.
      checkCycles(cycleCountModel(op), count);
   endtask

   task automatic resetTest();
      Reset = 1'b1;
      for (int i = 0; i < RESET_CYCLES; i++)
      begin
         #SAMPLE_DELAY;
         checkState(fetch);
         checkControl(wordModel(fetch, opcode));
         advanceCycle();
      end
      Reset = 1'b0; // state stays in fetch for the first instruction.
   endtask

   task automatic rTypeTest();
      for (int i = 0; i < 5; i++)
      begin
         runInstruction(opcodeT'(i));
      end
   endtask

   task automatic memoryTest();
      runInstruction(`OP_LW);
      runInstruction(`OP_SW);
   endtask

   task automatic branchJumpTest();
      runInstruction(`OP_BEQ);
      runInstruction(`OP_BNE);
      runInstruction(`OP_J);
      runInstruction(`OP_JR);
   endtask

   task automatic immediateTest();
      runInstruction(`OP_ADDI);
      runInstruction(`OP_LUI);
      runInstruction(`OP_LI);
   endtask

   task automatic illegalTest();
      runInstruction(4'd7);
      runInstruction(4'd13);
   endtask

   task automatic randomTest();
      repeat (RANDOM_COUNT)
      begin
         runInstruction(opcodeT'($random(seed)));
      end
   endtask

   initial
   begin
      Reset  = 1'b1;
      opcode = `OP_ADD;
      seed   = 32'h14b28b80;
      resetTest();
      rTypeTest();
      memoryTest();
      branchJumpTest();
      immediateTest();
      illegalTest();
      randomTest();
      $display("sim passed");
      $finish;
   end

endmodule

/* verification/control_props.sv */
`timescale 1ns/1ns

module controlProps
   import controlPkg::*;
(
   input logic        CLK,
   input logic        Reset,
   input stateT       state,
   input controlWordT control
);

   // every instruction leaves fetch through decode.
   property fetchThenDecode;
      @(posedge CLK) disable iff (Reset)
         (state == fetch) |=> (state == decode);
   endproperty

   property irWriteInFetch;
      @(posedge CLK) disable iff (Reset)
         control.irWrite |-> (state == fetch);
   endproperty

   property memWriteInStore;
      @(posedge CLK) disable iff (Reset)
         control.memWrite |-> (state == swDone);
   endproperty

   // only the pc update states may load the PC.
   property pcWriteStates;
      @(posedge CLK) disable iff (Reset)
         control.pcWrite |-> (state inside {fetch, beqDone, bneDone, jExecute, jrExecute});
   endproperty

   assert property (fetchThenDecode)
      else $error("fetch was not followed by decode");
   assert property (irWriteInFetch)
      else $error("irWrite high outside fetch");
   assert property (memWriteInStore)
      else $error("memWrite high outside swDone");
   assert property (pcWriteStates)
      else $error("pcWrite high in a state that does not update the PC");

endmodule

bind controlTop controlProps props
(
   .CLK     (CLK),
   .Reset   (Reset),
   .state   (state),
   .control (control)
);

/* verification/clockGen.sv */
`timescale 1ns/1ns

module clockGen
(
   output logic CLK
);

   localparam int HALF_PERIOD = 50; // 100 ns clock.

   initial
   begin
      CLK = 1'b0;
   end

   always #HALF_PERIOD CLK = ~CLK;

endmodule

/* src/controlTop.sv */
`timescale 1ns/1ns

module controlTop
   import controlPkg::*;
(
   input  logic        CLK,
   input  logic        Reset,
   input  opcodeT      opcode,
   output stateT       state,
   output controlWordT control
);

   instrInfoT info; // decoded opcode, shared by both consumers.

   opcodeDecoder opcodeDecoder
   (
      .opcode (opcode),
      .info   (info)
   );

   stateSequencer stateSequencer
   (
      .CLK   (CLK),
      .Reset (Reset),
      .info  (info),
      .state (state)
   );

   controlDecoder controlDecoder
   (
      .state   (state),
      .info    (info),
      .control (control)
   );

endmodule

/* src/controlDecoder.sv */
`timescale 1ns/1ns
`include "control_defines.svh"

module controlDecoder
   import controlPkg::*;
(
   input  stateT       state,
   input  instrInfoT   info,
   output controlWordT control
);

   always_comb
   begin
      control          = '0; // all strobes low unless a state raises them.
      control.pcSource = `PC_SRC_IDLE;
      case (state)
         fetch:
         begin
            control.aluOutSrc = 2'd1;
            control.aluSrc1   = 2'd2;
            control.aluSrc2   = 2'd1;
            control.aluOp     = `ALU_ADD; // pc + 4.
            control.irWrite   = 1'b1;
            control.pcWrite   = 1'b1;
            control.pcSource  = 2'd1;
         end
         decode:
         begin
            control.regWrite = 1'b1;
            control.aluSrc2  = 2'd2;
            control.aluOp    = `ALU_ADD;
         end
         rExecute:
         begin
            control.aluOutSrc = 2'd3;
            control.iorD      = 2'd1;
            control.mdrWrite  = 1'b1;
            control.aluSrc1   = 2'd3;
            control.aluOp     = info.aluFunc;
         end
         rWrite,
         iWrite:
         begin
            control.regWrite = 1'b1;
            control.regSrc   = 3'd4; // alu result.
         end
         address:
         begin
            control.aluOutSrc = 2'd3;
         end
         lwExecute:
         begin
            control.iorD = 2'd2;
         end
         swDone:
         begin
            control.memWrite = 1'b1;
            control.iorD     = 2'd1;
         end
         lwDone:
         begin
            control.regWrite = 1'b1;
            control.regSrc   = 3'd1; // memory data.
         end
         bExecute:
         begin
            // compare by subtraction.
            control.aluSrc1 = 2'd1;
            control.aluOp   = `ALU_SUB;
         end
         beqDone:
         begin
            control.beq       = 1'b1;
            control.aluOp     = `ALU_ADD;
            control.aluSrc1   = 2'd2;
            control.aluSrc2   = 2'd3;
            control.aluOutSrc = 2'd1;
            control.pcWrite   = 1'b1;
         end
         bneDone:
         begin
            control.bne       = 1'b1;
            control.aluOp     = `ALU_ADD;
            control.aluSrc1   = 2'd2;
            control.aluSrc2   = 2'd3;
            control.aluOutSrc = 2'd1;
            control.pcWrite   = 1'b1;
         end
         jExecute:
         begin
            control.pcWrite  = 1'b1;
            control.pcSource = 2'd2; // jump target.
         end
         jrExecute:
         begin
            control.iorD     = 2'd2;
            control.regWrite = 1'b1;
            control.pcWrite  = 1'b1;
            control.pcSource = 2'd1;
         end
         iExecute:
         begin
            control.aluOp = info.aluFunc;
         end
         luiExecute:
         begin
            control.regWrite = 1'b1;
            control.regSrc   = 3'd2;
         end
         liExecute:
         begin
            control.regWrite  = 1'b1;
            control.aluOutSrc = 2'd2;
         end
         default:
         begin
            // unused encodings keep the idle word.
            control.pcSource = `PC_SRC_IDLE;
         end
      endcase
   end

endmodule

/* src/stateSequencer.sv */
`timescale 1ns/1ns

module stateSequencer
   import controlPkg::*;
(
   input  logic      CLK,
   input  logic      Reset,
   input  instrInfoT info,
   output stateT     state
);

   stateT nextState;

   always_ff @(posedge CLK or posedge Reset)
   begin
      if (Reset)
      begin
         state <= fetch;
      end
      else
      begin
         state <= nextState;
      end
   end

   always_comb
   begin
      nextState = fetch; // last state of every flow.
      case (state)
         fetch:
         begin
            nextState = decode;
         end
         decode:
         begin
            case (info.instrClass)
               rType:     nextState = rExecute;
               store,
               load:      nextState = address;
               branchEq,
               branchNe:  nextState = bExecute;
               addImm:    nextState = iExecute;
               jump:      nextState = jExecute;
               jumpReg:   nextState = jrExecute;
               loadUpper: nextState = luiExecute;
               loadImm:   nextState = liExecute;
               default:   nextState = fetch; // illegal opcode is skipped.
            endcase
         end
         address:
         begin
            if (info.instrClass == store)
            begin
               nextState = swDone;
            end
            else
            begin
               nextState = lwExecute;
            end
         end
         lwExecute:
         begin
            nextState = lwDone;
         end
         bExecute:
         begin
            // the opcode is held, so the class still tells beq from bne.
            nextState = (info.instrClass == branchEq) ? beqDone : bneDone;
         end
         rExecute:
         begin
            nextState = rWrite;
         end
         iExecute:
         begin
            nextState = iWrite;
         end
         default:
         begin
            nextState = fetch;
         end
      endcase
   end

endmodule

/* src/opcodeDecoder.sv */
`timescale 1ns/1ns
`include "control_defines.svh"

module opcodeDecoder
   import controlPkg::*;
(
   input  opcodeT    opcode,
   output instrInfoT info
);

   always_comb
   begin
      info.instrClass = illegal; // 7, 13 and anything unlisted.
      info.aluFunc    = `ALU_ADD;
      case (opcode)
         `OP_ADD:
         begin
            info.instrClass = rType;
         end
         `OP_AND:
         begin
            info.instrClass = rType;
            info.aluFunc    = `ALU_AND;
         end
         `OP_OR:
         begin
            info.instrClass = rType;
            info.aluFunc    = `ALU_OR;
         end
         `OP_SUB:
         begin
            info.instrClass = rType;
            info.aluFunc    = `ALU_SUB;
         end
         `OP_SLT:
         begin
            info.instrClass = rType;
            info.aluFunc    = `ALU_SLT;
         end
         `OP_JR:   info.instrClass = jumpReg;
         `OP_SW:   info.instrClass = store;
         `OP_BEQ:  info.instrClass = branchEq;
         `OP_BNE:  info.instrClass = branchNe;
         `OP_LW:   info.instrClass = load;
         `OP_ADDI: info.instrClass = addImm;
         `OP_J:    info.instrClass = jump;
         `OP_LUI:  info.instrClass = loadUpper;
         `OP_LI:   info.instrClass = loadImm;
         default:
         begin
            info.instrClass = illegal;
         end
      endcase
   end

endmodule

/* src/controlPkg.sv */
package controlPkg;

`include "control_defines.svh"

   typedef logic [`OPCODE_WIDTH-1:0]  opcodeT;
   typedef logic [`ALU_OP_WIDTH-1:0]  aluOpT;
   typedef logic [`SEL_WIDTH-1:0]     selT;
   typedef logic [`REG_SRC_WIDTH-1:0] regSrcT;

   // encodings follow the original numbering, 13 is left unused.
   typedef enum logic [`STATE_WIDTH-1:0] {
      fetch      = 5'd0,
      decode     = 5'd1,
      rExecute   = 5'd2,
      rWrite     = 5'd3,
      address    = 5'd4,
      lwExecute  = 5'd5,
      swDone     = 5'd6,
      lwDone     = 5'd7,
      jExecute   = 5'd8,
      jrExecute  = 5'd9,
      bExecute   = 5'd10,
      bneDone    = 5'd11,
      beqDone    = 5'd12,
      iExecute   = 5'd14,
      iWrite     = 5'd15,
      luiExecute = 5'd16,
      liExecute  = 5'd17
   } stateT;

   typedef enum logic [3:0] {
      rType, jumpReg, store, load, branchEq, branchNe,
      addImm, jump, loadUpper, loadImm, illegal
   } instrClassT;

   typedef struct packed {
      instrClassT instrClass;
      aluOpT      aluFunc;
   } instrInfoT;

   typedef struct packed {
      aluOpT  aluOp;
      selT    aluSrc1;
      selT    aluSrc2;
      selT    aluOutSrc;
      selT    pcSource;
      selT    iorD;
      regSrcT regSrc;
      logic   regWrite;
      logic   memWrite;
      logic   irWrite;
      logic   pcWrite;
      logic   mdrWrite;
      logic   beq;
      logic   bne;
   } controlWordT;

endpackage

/* src/control_defines.svh */
`ifndef CONTROL_DEFINES_SVH
`define CONTROL_DEFINES_SVH

// field widths.
`define OPCODE_WIDTH 4
`define STATE_WIDTH  5
`define ALU_OP_WIDTH 3
`define SEL_WIDTH    2
`define REG_SRC_WIDTH 3

// opcode field values as seen in the IR.
`define OP_ADD  4'd0
`define OP_AND  4'd1
`define OP_OR   4'd2
`define OP_SUB  4'd3
`define OP_SLT  4'd4
`define OP_JR   4'd5
`define OP_SW   4'd6
`define OP_BEQ  4'd8
`define OP_BNE  4'd9
`define OP_LW   4'd10
`define OP_ADDI 4'd11
`define OP_J    4'd12
`define OP_LUI  4'd14
`define OP_LI   4'd15

// datapath ALU function codes.
`define ALU_AND 3'd0
`define ALU_OR  3'd1
`define ALU_ADD 3'd2
`define ALU_SUB 3'd6
`define ALU_SLT 3'd7

// pc mux is parked here whenever the PC is not written.
`define PC_SRC_IDLE 2'd3

`endif
